// File: source/opl_reg_pkg.sv
// OPL register map
// group bases, field widths and packed register fields
package opl_reg_pkg;
    localparam int REG_W = 8;

    typedef logic [REG_W-1:0] reg_addr_t;
    typedef logic [REG_W-1:0] reg_data_t;

    localparam int MULT_W = 4;
    localparam int KSL_W = 2;
    localparam int TL_W = 6;
    localparam int ENV_W = 4;  // ar, dr, sl and rr
    localparam int WS_W = 3;
    localparam int FNUM_W = 10;
    localparam int FNUM_LO_W = 8;
    localparam int BLOCK_W = 3;
    localparam int FB_W = 3;

    localparam reg_addr_t OP_GROUP_SPAN = 8'h16;  // 18 operators spread over 22 offsets
    localparam reg_addr_t CH_GROUP_SPAN = 8'h09;

    localparam reg_addr_t OP_CTRL_BASE = 8'h20;
    localparam reg_addr_t OP_LEVEL_BASE = 8'h40;
    localparam reg_addr_t OP_AD_BASE = 8'h60;
    localparam reg_addr_t OP_SR_BASE = 8'h80;
    localparam reg_addr_t CH_FNUM_LO_BASE = 8'hA0;
    localparam reg_addr_t CH_KBF_BASE = 8'hB0;
    localparam reg_addr_t CH_FBC_BASE = 8'hC0;
    localparam reg_addr_t OP_WS_BASE = 8'hE0;

    typedef struct packed {
        logic am;   // tremolo on
        logic vib;  // vibrato on
        logic egt;  // sustained envelope
        logic ksr;
        logic [MULT_W-1:0] mult;
    } op_ctrl_t;

    typedef struct packed {
        logic [KSL_W-1:0] ksl;
        logic [TL_W-1:0] tl;
    } op_level_t;

    typedef struct packed {
        logic [ENV_W-1:0] ar;
        logic [ENV_W-1:0] dr;
    } op_ad_t;

    typedef struct packed {
        logic [ENV_W-1:0] sl;
        logic [ENV_W-1:0] rr;
    } op_sr_t;

    typedef logic [WS_W-1:0] op_ws_t;
    typedef logic [FNUM_LO_W-1:0] ch_fnum_lo_t;

    typedef struct packed {
        logic kon;
        logic [BLOCK_W-1:0] block;
        logic [FNUM_W-FNUM_LO_W-1:0] fnum_hi;
    } ch_kbf_t;

    typedef struct packed {
        logic [FB_W-1:0] fb;
        logic cnt;
    } ch_fbc_t;
endpackage

// File: source/opl_slot_pkg.sv
// Operator slot numbering
package opl_slot_pkg;
    localparam int NUM_BANKS = 2;
    localparam int OPS_PER_BANK = 18;
    localparam int CHS_PER_BANK = OPS_PER_BANK / 2;
    localparam int PAIRS_PER_BANK = 3;  // channels 0-2 pair with 3-5
    localparam int NUM_SLOTS = NUM_BANKS * OPS_PER_BANK;

    typedef logic [$clog2(NUM_BANKS)-1:0] bank_t;
    typedef logic [$clog2(OPS_PER_BANK)-1:0] op_num_t;
    typedef logic [$clog2(CHS_PER_BANK)-1:0] ch_num_t;
    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_num_t;

    // one bit per pairable channel, index bank * 3 + channel
    typedef logic [NUM_BANKS*PAIRS_PER_BANK-1:0] conn_sel_t;
endpackage

// File: source/reg_bank_mem.sv
// Banked register memory
`timescale 1ns/1ps

module reg_bank_mem #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 16,
    parameter int NUM_BANKS = 2
) (
    input  logic clk,

    input  logic wr_en,
    input  logic [$clog2(NUM_BANKS)-1:0] wr_bank,
    input  logic [$clog2(DEPTH)-1:0] wr_offset,
    input  payload_t wr_payload,

    input  logic rd_en,
    input  logic [$clog2(NUM_BANKS)-1:0] rd_bank,
    input  logic [$clog2(DEPTH)-1:0] rd_offset,
    output payload_t rd_payload
);
    payload_t mem [NUM_BANKS][DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_offset] <= wr_payload;
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_payload <= mem[rd_bank][rd_offset];
        end
    end
endmodule

// File: source/operator_regs.sv
// Per-operator register file
`timescale 1ns/1ps

module operator_regs (
    input  logic clk,

    input  logic wr_valid,
    input  opl_slot_pkg::bank_t wr_bank,
    input  opl_reg_pkg::reg_addr_t wr_address,
    input  opl_reg_pkg::reg_data_t wr_data,

    input  logic rd_en,
    input  opl_slot_pkg::bank_t rd_bank,
    input  opl_slot_pkg::op_num_t rd_op,

    output logic am,
    output logic vib,
    output logic egt,
    output logic ksr,
    output logic [opl_reg_pkg::MULT_W-1:0] mult,
    output logic [opl_reg_pkg::KSL_W-1:0] ksl,
    output logic [opl_reg_pkg::TL_W-1:0] tl,
    output logic [opl_reg_pkg::ENV_W-1:0] ar,
    output logic [opl_reg_pkg::ENV_W-1:0] dr,
    output logic [opl_reg_pkg::ENV_W-1:0] sl,
    output logic [opl_reg_pkg::ENV_W-1:0] rr,
    output logic [opl_reg_pkg::WS_W-1:0] ws
);
    import opl_reg_pkg::*;
    import opl_slot_pkg::*;

    localparam int OFF_W = $clog2(OP_GROUP_SPAN);

    reg_addr_t ctrl_rel, level_rel, ad_rel, sr_rel, ws_rel;
    logic [OFF_W-1:0] rd_offset;
    op_ctrl_t ctrl_q;
    op_level_t level_q;
    op_ad_t ad_q;
    op_sr_t sr_q;
    op_ws_t ws_q;

    // offset inside each group, wraps high when below the base
    assign ctrl_rel = wr_address - OP_CTRL_BASE;
    assign level_rel = wr_address - OP_LEVEL_BASE;
    assign ad_rel = wr_address - OP_AD_BASE;
    assign sr_rel = wr_address - OP_SR_BASE;
    assign ws_rel = wr_address - OP_WS_BASE;

    // offsets 6,7 and 0Eh,0Fh hold no operator
    always_comb begin
        if (rd_op < op_num_t'(6)) begin
            rd_offset = OFF_W'(rd_op);
        end else if (rd_op < op_num_t'(12)) begin
            rd_offset = OFF_W'(rd_op + op_num_t'(2));
        end else begin
            rd_offset = OFF_W'(rd_op + op_num_t'(4));
        end
    end

    reg_bank_mem #(.payload_t(op_ctrl_t), .DEPTH(OP_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_ctrl_mem (
        .clk, .wr_en(wr_valid && ctrl_rel < OP_GROUP_SPAN), .wr_bank,
        .wr_offset(ctrl_rel[OFF_W-1:0]), .wr_payload(op_ctrl_t'(wr_data)),
        .rd_en, .rd_bank, .rd_offset, .rd_payload(ctrl_q)
    );

    reg_bank_mem #(.payload_t(op_level_t), .DEPTH(OP_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_level_mem (
        .clk, .wr_en(wr_valid && level_rel < OP_GROUP_SPAN), .wr_bank,
        .wr_offset(level_rel[OFF_W-1:0]), .wr_payload(op_level_t'(wr_data)),
        .rd_en, .rd_bank, .rd_offset, .rd_payload(level_q)
    );

    reg_bank_mem #(.payload_t(op_ad_t), .DEPTH(OP_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_ad_mem (
        .clk, .wr_en(wr_valid && ad_rel < OP_GROUP_SPAN), .wr_bank,
        .wr_offset(ad_rel[OFF_W-1:0]), .wr_payload(op_ad_t'(wr_data)),
        .rd_en, .rd_bank, .rd_offset, .rd_payload(ad_q)
    );

    reg_bank_mem #(.payload_t(op_sr_t), .DEPTH(OP_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_sr_mem (
        .clk, .wr_en(wr_valid && sr_rel < OP_GROUP_SPAN), .wr_bank,
        .wr_offset(sr_rel[OFF_W-1:0]), .wr_payload(op_sr_t'(wr_data)),
        .rd_en, .rd_bank, .rd_offset, .rd_payload(sr_q)
    );

    reg_bank_mem #(.payload_t(op_ws_t), .DEPTH(OP_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_ws_mem (
        .clk, .wr_en(wr_valid && ws_rel < OP_GROUP_SPAN), .wr_bank,
        .wr_offset(ws_rel[OFF_W-1:0]), .wr_payload(wr_data[WS_W-1:0]),
        .rd_en, .rd_bank, .rd_offset, .rd_payload(ws_q)
    );

    assign am = ctrl_q.am;
    assign vib = ctrl_q.vib;
    assign egt = ctrl_q.egt;
    assign ksr = ctrl_q.ksr;
    assign mult = ctrl_q.mult;
    assign ksl = level_q.ksl;
    assign tl = level_q.tl;
    assign ar = ad_q.ar;
    assign dr = ad_q.dr;
    assign sl = sr_q.sl;
    assign rr = sr_q.rr;
    assign ws = ws_q;
endmodule

// File: source/channel_regs.sv
// Per-channel register file
// 2-op and 4-op channel lookup for each operator slot
`timescale 1ns/1ps

module channel_regs (
    input  logic clk,
    input  logic rst_n,

    input  logic wr_valid,
    input  opl_slot_pkg::bank_t wr_bank,
    input  opl_reg_pkg::reg_addr_t wr_address,
    input  opl_reg_pkg::reg_data_t wr_data,

    input  opl_slot_pkg::conn_sel_t conn_sel,

    input  logic rd_en,
    input  opl_slot_pkg::bank_t rd_bank,
    input  opl_slot_pkg::op_num_t rd_op,

    output logic [opl_reg_pkg::FNUM_W-1:0] fnum,
    output logic [opl_reg_pkg::BLOCK_W-1:0] block,
    output logic kon,
    output logic [opl_reg_pkg::FB_W-1:0] fb,
    output logic cnt
);
    import opl_reg_pkg::*;
    import opl_slot_pkg::*;

    localparam int OFF_W = $clog2(CH_GROUP_SPAN);
    localparam int CONN_IDX_W = $clog2($bits(conn_sel_t));

    reg_addr_t fnum_rel, kbf_rel, fbc_rel;
    conn_sel_t conn_q;
    op_num_t op_grp;
    op_num_t op_pos;
    logic [CONN_IDX_W-1:0] conn_idx;
    ch_num_t rd_ch;
    ch_fnum_lo_t fnum_lo_q;
    ch_kbf_t kbf_q;
    ch_fbc_t fbc_q;

    assign fnum_rel = wr_address - CH_FNUM_LO_BASE;
    assign kbf_rel = wr_address - CH_KBF_BASE;
    assign fbc_rel = wr_address - CH_FBC_BASE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conn_q <= '0;
        end else begin
            conn_q <= conn_sel;  // local copy of the 4-op enables
        end
    end

    // ops 0-5 -> ch 0-2, ops 6-11 -> ch 3-5, ops 12-17 -> ch 6-8
    always_comb begin
        op_grp = rd_op / op_num_t'(6);
        op_pos = rd_op % op_num_t'(3);
        conn_idx = CONN_IDX_W'(rd_bank) * CONN_IDX_W'(PAIRS_PER_BANK) + CONN_IDX_W'(op_pos);
        rd_ch = ch_num_t'(op_grp * op_num_t'(3) + op_pos);
        // a paired operator takes the lower channel of its 4-op pair
        if (op_grp == op_num_t'(1) && conn_q[conn_idx]) begin
            rd_ch = rd_ch - ch_num_t'(PAIRS_PER_BANK);
        end
    end

    reg_bank_mem #(.payload_t(ch_fnum_lo_t), .DEPTH(CH_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_fnum_mem (
        .clk, .wr_en(wr_valid && fnum_rel < CH_GROUP_SPAN), .wr_bank,
        .wr_offset(fnum_rel[OFF_W-1:0]), .wr_payload(wr_data),
        .rd_en, .rd_bank, .rd_offset(rd_ch), .rd_payload(fnum_lo_q)
    );

    reg_bank_mem #(.payload_t(ch_kbf_t), .DEPTH(CH_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_kbf_mem (
        .clk, .wr_en(wr_valid && kbf_rel < CH_GROUP_SPAN), .wr_bank,
        .wr_offset(kbf_rel[OFF_W-1:0]), .wr_payload(ch_kbf_t'(wr_data[$bits(ch_kbf_t)-1:0])),
        .rd_en, .rd_bank, .rd_offset(rd_ch), .rd_payload(kbf_q)
    );

    reg_bank_mem #(.payload_t(ch_fbc_t), .DEPTH(CH_GROUP_SPAN), .NUM_BANKS(NUM_BANKS)) u_fbc_mem (
        .clk, .wr_en(wr_valid && fbc_rel < CH_GROUP_SPAN), .wr_bank,
        .wr_offset(fbc_rel[OFF_W-1:0]), .wr_payload(ch_fbc_t'(wr_data[$bits(ch_fbc_t)-1:0])),
        .rd_en, .rd_bank, .rd_offset(rd_ch), .rd_payload(fbc_q)
    );

    assign fnum = {kbf_q.fnum_hi, fnum_lo_q};
    assign block = kbf_q.block;
    assign kon = kbf_q.kon;
    assign fb = fbc_q.fb;
    assign cnt = fbc_q.cnt;
endmodule

// File: source/slot_sequencer.sv
// Operator slot sweep sequencer
`timescale 1ns/1ps

module slot_sequencer #(
    parameter int SLOT_CYCLES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sample_en,

    output logic busy,

    output logic rd_en,
    output opl_slot_pkg::bank_t rd_bank,
    output opl_slot_pkg::op_num_t rd_op,

    output logic slot_valid,
    output opl_slot_pkg::bank_t slot_bank,
    output opl_slot_pkg::op_num_t slot_op,

    output logic sweep_done
);
    import opl_slot_pkg::*;

    localparam int STATE_W = $clog2(NUM_SLOTS + 1);
    localparam int CNT_W = (SLOT_CYCLES > 1) ? $clog2(SLOT_CYCLES) : 1;
    localparam logic [STATE_W-1:0] IDLE = '0;

    logic [STATE_W-1:0] state;  // 0 idle, s + 1 while in slot s
    logic [CNT_W-1:0] cycle_cnt;
    slot_num_t slot;
    logic start;
    logic slot_end;
    logic last_valid;

    assign start = sample_en && !busy;
    assign slot_end = cycle_cnt == CNT_W'(SLOT_CYCLES - 1);
    assign last_valid = slot_valid && slot_bank == bank_t'(NUM_BANKS - 1) &&
                        slot_op == op_num_t'(OPS_PER_BANK - 1);

    assign slot = slot_num_t'(state - STATE_W'(1));
    assign rd_en = state != IDLE && cycle_cnt == '0;  // first cycle of a slot
    assign rd_bank = bank_t'(slot >= slot_num_t'(OPS_PER_BANK));
    assign rd_op = rd_bank ? op_num_t'(slot - slot_num_t'(OPS_PER_BANK)) : op_num_t'(slot);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cycle_cnt <= '0;
        end else if (start) begin
            state <= STATE_W'(1);
            cycle_cnt <= '0;
        end else if (state != IDLE) begin
            if (slot_end) begin
                cycle_cnt <= '0;
                state <= (state == STATE_W'(NUM_SLOTS)) ? IDLE : state + 1'b1;
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    // busy covers the read of the last slot, not only its slot state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            sweep_done <= 1'b0;
            slot_valid <= 1'b0;
            slot_bank <= '0;
            slot_op <= '0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (last_valid) begin
                busy <= 1'b0;
            end
            sweep_done <= last_valid;
            slot_valid <= rd_en;  // aligned with the registered memory read
            slot_bank <= rd_bank;
            slot_op <= rd_op;
        end
    end
endmodule

// File: source/op_param_fetch.sv
// Operator parameter fetch engine
`timescale 1ns/1ps

module op_param_fetch #(
    parameter int SLOT_CYCLES = 2
) (
    input  logic clk,
    input  logic rst_n,

    input  logic wr_valid,
    input  opl_slot_pkg::bank_t wr_bank,
    input  opl_reg_pkg::reg_addr_t wr_address,
    input  opl_reg_pkg::reg_data_t wr_data,

    input  opl_slot_pkg::conn_sel_t conn_sel,
    input  logic sample_en,

    output logic busy,
    output logic slot_valid,
    output opl_slot_pkg::bank_t slot_bank,
    output opl_slot_pkg::op_num_t slot_op,
    output logic sweep_done,

    output logic am,
    output logic vib,
    output logic egt,
    output logic ksr,
    output logic [opl_reg_pkg::MULT_W-1:0] mult,
    output logic [opl_reg_pkg::KSL_W-1:0] ksl,
    output logic [opl_reg_pkg::TL_W-1:0] tl,
    output logic [opl_reg_pkg::ENV_W-1:0] ar,
    output logic [opl_reg_pkg::ENV_W-1:0] dr,
    output logic [opl_reg_pkg::ENV_W-1:0] sl,
    output logic [opl_reg_pkg::ENV_W-1:0] rr,
    output logic [opl_reg_pkg::WS_W-1:0] ws,

    output logic [opl_reg_pkg::FNUM_W-1:0] fnum,
    output logic [opl_reg_pkg::BLOCK_W-1:0] block,
    output logic kon,
    output logic [opl_reg_pkg::FB_W-1:0] fb,
    output logic cnt
);
    import opl_slot_pkg::*;

    logic rd_en;  // shared read strobe for both register files
    bank_t rd_bank;
    op_num_t rd_op;

    slot_sequencer #(.SLOT_CYCLES(SLOT_CYCLES)) u_seq (
        .clk, .rst_n, .sample_en, .busy,
        .rd_en, .rd_bank, .rd_op,
        .slot_valid, .slot_bank, .slot_op, .sweep_done
    );

    operator_regs u_op_regs (
        .clk, .wr_valid, .wr_bank, .wr_address, .wr_data,
        .rd_en, .rd_bank, .rd_op,
        .am, .vib, .egt, .ksr, .mult, .ksl, .tl, .ar, .dr, .sl, .rr, .ws
    );

    channel_regs u_ch_regs (
        .clk, .rst_n, .wr_valid, .wr_bank, .wr_address, .wr_data,
        .conn_sel, .rd_en, .rd_bank, .rd_op,
        .fnum, .block, .kon, .fb, .cnt
    );
endmodule

// File: verification/tb_op_param_fetch.sv
// Operator parameter fetch testbench
`timescale 1ns/1ps

module tb_op_param_fetch;
    import opl_reg_pkg::*;
    import opl_slot_pkg::*;

    localparam int SLOT_TIMEOUT = 20;  // cycles allowed per wait
    localparam logic [31:0] SEED = 32'h4d9b_418f;
    localparam reg_addr_t GROUP_BASES [8] = '{OP_CTRL_BASE, OP_LEVEL_BASE, OP_AD_BASE,
        OP_SR_BASE, OP_WS_BASE, CH_FNUM_LO_BASE, CH_KBF_BASE, CH_FBC_BASE};
    localparam reg_addr_t OP_OFFSETS [7] = '{8'h00, 8'h05, 8'h06, 8'h08, 8'h0D, 8'h10, 8'h15};

    typedef struct {
        string name;
        conn_sel_t conn;
        int n_rand;
        int dir_kind;  // 0 none, 1 operator groups, 2 channel groups
        bit mid_pulse;
    } test_row_t;

    test_row_t rows [6] = '{
        '{"reset_zero", 6'b000000, 0, 0, 1'b0},
        '{"op_offsets", 6'b000000, 0, 1, 1'b0},
        '{"ch_2op", 6'b000000, 0, 2, 1'b0},
        '{"ch_4op", 6'b101001, 0, 0, 1'b0},
        '{"random", 6'b010110, 400, 0, 1'b1},
        '{"random_4op", 6'b101001, 200, 0, 1'b0}
    };

    logic clk = 1'b0;
    logic rst_n;
    logic wr_valid;
    bank_t wr_bank;
    reg_addr_t wr_address;
    reg_data_t wr_data;
    conn_sel_t conn_sel;
    logic sample_en;
    logic busy;
    logic slot_valid;
    bank_t slot_bank;
    op_num_t slot_op;
    logic sweep_done;
    logic am;
    logic vib;
    logic egt;
    logic ksr;
    logic [MULT_W-1:0] mult;
    logic [KSL_W-1:0] ksl;
    logic [TL_W-1:0] tl;
    logic [ENV_W-1:0] ar;
    logic [ENV_W-1:0] dr;
    logic [ENV_W-1:0] sl;
    logic [ENV_W-1:0] rr;
    logic [WS_W-1:0] ws;
    logic [FNUM_W-1:0] fnum;
    logic [BLOCK_W-1:0] block;
    logic kon;
    logic [FB_W-1:0] fb;
    logic cnt;

    reg_data_t shadow [NUM_BANKS][256];  // copy of every written register
    logic [31:0] rng;
    int cur_bank;
    int cur_op;
    int checks;
    int errors;

    always #5 clk = ~clk;

    op_param_fetch #(.SLOT_CYCLES(2)) u_dut (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch %s at bank %0d op %0d: got %h, expected %h",
                     name, cur_bank, cur_op, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input int b, input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        wr_valid = 1'b1;
        wr_bank = bank_t'(b);
        wr_address = addr;
        wr_data = data;
        shadow[b][addr] = data;
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic apply_directed(input int kind);
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (kind == 1) begin
                for (int g = 0; g < 5; g++)
                    for (int i = 0; i < 7; i++)
                        write_reg(b, GROUP_BASES[g] + OP_OFFSETS[i],
                                  reg_data_t'(8'h3c + 97 * b + 37 * g + 11 * i));
            end else if (kind == 2) begin
                for (int g = 5; g < 8; g++)
                    for (int ch = 0; ch < 9; ch++)
                        write_reg(b, GROUP_BASES[g] + reg_addr_t'(ch),
                                  reg_data_t'(8'h71 + 53 * b + 29 * g + 13 * ch));
            end
        end
    endtask

    task automatic random_writes(input int n);
        int g;
        int span;
        for (int i = 0; i < n; i++) begin
            rng = lcg_next(rng);
            g = int'(rng[30:28]);  // upper bits, low LCG bits repeat quickly
            span = (g < 5) ? int'(OP_GROUP_SPAN) : int'(CH_GROUP_SPAN);
            write_reg(int'(rng[31]), GROUP_BASES[g] + reg_addr_t'(int'(rng[23:16]) % span),
                      rng[15:8]);
        end
    endtask

    task automatic check_slot(input int b, input int op);
        int off;
        int ch;
        reg_data_t ctrl, level, ad, sr, wsel, flo, kbf, fbc;
        off = (op < 6) ? op : (op < 12) ? op + 2 : op + 4;
        ch = 3 * (op / 6) + op % 3;
        if (op >= 6 && op < 12 && conn_sel[b * 3 + op % 3]) begin
            ch = ch - 3;  // lower channel of the 4-op pair
        end
        ctrl = shadow[b][OP_CTRL_BASE + off];
        level = shadow[b][OP_LEVEL_BASE + off];
        ad = shadow[b][OP_AD_BASE + off];
        sr = shadow[b][OP_SR_BASE + off];
        wsel = shadow[b][OP_WS_BASE + off];
        flo = shadow[b][CH_FNUM_LO_BASE + ch];
        kbf = shadow[b][CH_KBF_BASE + ch];
        fbc = shadow[b][CH_FBC_BASE + ch];
        check_field("am", am, ctrl[7]);
        check_field("vib", vib, ctrl[6]);
        check_field("egt", egt, ctrl[5]);
        check_field("ksr", ksr, ctrl[4]);
        check_field("mult", mult, ctrl[3:0]);
        check_field("ksl", ksl, level[7:6]);
        check_field("tl", tl, level[5:0]);
        check_field("ar", ar, ad[7:4]);
        check_field("dr", dr, ad[3:0]);
        check_field("sl", sl, sr[7:4]);
        check_field("rr", rr, sr[3:0]);
        check_field("ws", ws, wsel[2:0]);
        check_field("fnum", fnum, {kbf[1:0], flo});
        check_field("block", block, kbf[4:2]);
        check_field("kon", kon, kbf[5]);
        check_field("fb", fb, fbc[3:1]);
        check_field("cnt", cnt, fbc[0]);
    endtask

    // one full sweep, every slot checked for timing and contents
    task automatic run_sweep(input bit mid_pulse);
        int since;
        @(negedge clk);
        sample_en = 1'b1;
        since = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            cur_bank = s / OPS_PER_BANK;
            cur_op = s % OPS_PER_BANK;
            do begin
                @(negedge clk);
                sample_en = 1'b0;
                since++;
            end while (!slot_valid && since < SLOT_TIMEOUT);
            if (!slot_valid) begin
                $display("Timeout waiting for slot_valid of slot %0d", s);
                errors++;
                return;
            end
            if (since != 2) begin
                $display("Slot %0d arrived %0d cycles after the previous event, not 2", s, since);
                errors++;
            end
            check_field("slot_bank", slot_bank, cur_bank);
            check_field("slot_op", slot_op, cur_op);
            check_slot(cur_bank, cur_op);
            if (mid_pulse && s == 10) begin
                sample_en = 1'b1;  // must be ignored while busy
            end
            since = 0;
        end
        do begin
            @(negedge clk);
            since++;
        end while (!sweep_done && since < SLOT_TIMEOUT);
        if (!sweep_done) begin
            $display("Timeout waiting for sweep_done");
            errors++;
        end else if (since != 1) begin
            $display("sweep_done arrived %0d cycles after the last slot, not 1", since);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("Mismatch busy at sweep_done: got %h, expected 0", busy);
            errors++;
        end
    endtask

    initial begin
        int err0;
        rst_n = 1'b0;
        wr_valid = 1'b0;
        wr_bank = '0;
        wr_address = '0;
        wr_data = '0;
        conn_sel = '0;
        sample_en = 1'b0;
        rng = SEED;
        checks = 0;
        errors = 0;
        for (int b = 0; b < NUM_BANKS; b++)
            for (int a = 0; a < 256; a++)
                shadow[b][a] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (slot_valid !== 1'b0 || sweep_done !== 1'b0 || busy !== 1'b0) begin
            $display("Mismatch after reset: slot_valid %h sweep_done %h busy %h, expected 0",
                     slot_valid, sweep_done, busy);
            errors++;
        end
        foreach (rows[i]) begin
            err0 = errors;
            @(negedge clk);
            conn_sel = rows[i].conn;
            apply_directed(rows[i].dir_kind);
            random_writes(rows[i].n_rand);
            run_sweep(rows[i].mid_pulse);
            $display("test %0d %-11s %s", i, rows[i].name, (errors == err0) ? "pass" : "fail");
        end
        $display("%0d tests, %0d checks, %0d errors", $size(rows), checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

// File: verification/op_param_fetch_sva.sv
// Slot sequencer timing assertions
`timescale 1ns/1ps

module op_param_fetch_sva (
    input  logic clk,
    input  logic rst_n,
    input  logic busy,
    input  logic rd_en,
    input  logic slot_valid,
    input  logic sweep_done
);
    // each read strobe gives a valid slot next cycle, still inside the sweep
    a_valid_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |=> slot_valid && busy)
        else $error("slot_valid does not follow rd_en by one cycle within the sweep");

    a_read_only_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> busy)
        else $error("rd_en asserted while busy is low");

    a_done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sweep_done |=> !sweep_done)
        else $error("sweep_done held for more than one cycle");
endmodule

bind slot_sequencer op_param_fetch_sva u_sva (
    .clk, .rst_n, .busy, .rd_en, .slot_valid, .sweep_done
);

// File: files.f
source/opl_reg_pkg.sv
source/opl_slot_pkg.sv
source/reg_bank_mem.sv
source/operator_regs.sv
source/channel_regs.sv
source/slot_sequencer.sv
source/op_param_fetch.sv
verification/tb_op_param_fetch.sv
verification/op_param_fetch_sva.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_op_param_fetch -f files.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
grep -q "SIMULATION PASSED" sim.log
